// ==== src/csr_config.svh ====
// csr unit config: data width, csr map, funct3 codes, trap causes and reset values
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

`define CSR_XLEN 32  // rv32 data path

// machine information registers
`define CSR_ADDR_MVENDORID 12'hF11
`define CSR_ADDR_MARCHID   12'hF12
`define CSR_ADDR_MIMPID    12'hF13
`define CSR_ADDR_MHARTID   12'hF14

// trap setup and handling
`define CSR_ADDR_MSTATUS  12'h300
`define CSR_ADDR_MISA     12'h301
`define CSR_ADDR_MIE      12'h304
`define CSR_ADDR_MTVEC    12'h305
`define CSR_ADDR_MSCRATCH 12'h340
`define CSR_ADDR_MEPC     12'h341
`define CSR_ADDR_MCAUSE   12'h342
`define CSR_ADDR_MIP      12'h344

// funct3 of the zicsr instructions
`define CSR_OP_RW  3'b001
`define CSR_OP_RS  3'b010
`define CSR_OP_RC  3'b011
`define CSR_OP_RWI 3'b101
`define CSR_OP_RSI 3'b110
`define CSR_OP_RCI 3'b111

`define CSR_CAUSE_EXT_IRQ   4'd11  // machine external interrupt
`define CSR_CAUSE_SW_IRQ    4'd3
`define CSR_CAUSE_TIMER_IRQ 4'd7
`define CSR_CAUSE_ILLEGAL   4'd2
`define CSR_CAUSE_ECALL     4'd11  // ecall from m-mode
`define CSR_CAUSE_EBREAK    4'd3

`define CSR_MISA_VALUE      32'h4000_0100  // mxl=1 with the i extension
`define CSR_TRAP_ADDR_RESET 32'h0000_0000  // mtvec after reset, direct mode

`endif

// ==== src/csr_pkg.sv ====
// csr package: packed bundles passed between the csr unit blocks and the testbench
package csr_pkg;

`include "csr_config.svh"

  // csr instruction sitting in execute
  typedef struct packed {
    logic                 valid;     // system opcode in this stage
    logic [2:0]           funct3;    // csr operation
    logic [11:0]          addr;      // csr index from the immediate
    logic [4:0]           rs1;       // rs1 index, also the zimm operand
    logic [`CSR_XLEN-1:0] rs1_data;  // register operand
  } csr_instr_t;

  // interrupt pins
  typedef struct packed {
    logic ext;
    logic sw;
    logic timer;
  } irq_t;

  // exception and return strobes from decode
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic ebreak;
    logic mret;
  } except_t;

  // csr bits that steer trap detection
  typedef struct packed {
    logic mstatus_mie;  // global enable
    logic meie;
    logic msie;
    logic mtie;
    logic meip;         // pending bits as sampled
    logic msip;
    logic mtip;
    logic mtvec_vec;    // vectored mode
  } csr_state_t;

  // per-cycle trap decision
  typedef struct packed {
    logic       take_trap;     // first cycle of a trap only
    logic       take_mret;
    logic       is_interrupt;
    logic [3:0] cause;
  } trap_cmd_t;

endpackage

// ==== src/csr_trap_ctrl.sv ====
// trap controller: detects interrupts and exceptions, picks the cause, makes trap and mret pulses
`timescale 1ns/10ps
`include "csr_config.svh"

module csr_trap_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  logic                clk_en,
  input  logic                writeback_change_pc,
  input  csr_pkg::except_t    exc,
  input  csr_pkg::csr_state_t state,
  output csr_pkg::trap_cmd_t  cmd,
  output logic                go_to_trap_q,        // one cycle after trap entry
  output logic                return_from_trap_q   // one cycle after mret
);

  logic ext_pend;   // enabled and pending
  logic sw_pend;
  logic tmr_pend;
  logic irq_any;
  logic exc_any;
  logic trap_det;   // some trap wants in this cycle

  // interrupt pending needs the global enable, its own enable and its pending bit
  always_comb begin
    ext_pend = state.mstatus_mie & state.meie & state.meip;
    sw_pend  = state.mstatus_mie & state.msie & state.msip;
    tmr_pend = state.mstatus_mie & state.mtie & state.mtip;
    irq_any  = ext_pend | sw_pend | tmr_pend;
  end

  // a flushed instruction raises nothing
  assign exc_any  = (exc.illegal | exc.ecall | exc.ebreak) & ~writeback_change_pc;
  assign trap_det = clk_en & (irq_any | exc_any);

  always_comb begin
    cmd.take_trap    = trap_det & ~go_to_trap_q;  // enter once per event
    // mret loses to a trap in the same cycle
    cmd.take_mret    = clk_en & exc.mret & ~writeback_change_pc & ~trap_det;
    cmd.is_interrupt = irq_any;
    // interrupts first, ext > sw > timer, then sync exceptions
    if (ext_pend) begin
      cmd.cause = `CSR_CAUSE_EXT_IRQ;
    end else if (sw_pend) begin
      cmd.cause = `CSR_CAUSE_SW_IRQ;
    end else if (tmr_pend) begin
      cmd.cause = `CSR_CAUSE_TIMER_IRQ;
    end else if (exc.illegal) begin
      cmd.cause = `CSR_CAUSE_ILLEGAL;
    end else if (exc.ecall) begin
      cmd.cause = `CSR_CAUSE_ECALL;
    end else if (exc.ebreak) begin
      cmd.cause = `CSR_CAUSE_EBREAK;
    end else begin
      cmd.cause = 4'd0;  // no trap, value unused
    end
  end

  // registered pulses toward fetch
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      go_to_trap_q       <= 1'b0;
      return_from_trap_q <= 1'b0;
    end else if (clk_en) begin
      go_to_trap_q       <= cmd.take_trap;
      return_from_trap_q <= cmd.take_mret;
    end else begin
      // a stalled stage must not redirect the pc
      go_to_trap_q       <= 1'b0;
      return_from_trap_q <= 1'b0;
    end
  end

endmodule

// ==== src/csr_rmw_alu.sv ====
// csr rmw alu: new csr value from the funct3 operation, old value and operand
`timescale 1ns/10ps
`include "csr_config.svh"

module csr_rmw_alu (
  input  logic [2:0]           funct3,
  input  logic [`CSR_XLEN-1:0] old_value,
  input  logic [4:0]           rs1,        // zimm for the immediate forms
  input  logic [`CSR_XLEN-1:0] rs1_data,
  output logic [`CSR_XLEN-1:0] new_value
);

  logic [`CSR_XLEN-1:0] operand;

  // funct3[2] marks the immediate forms
  assign operand = funct3[2] ? {{(`CSR_XLEN-5){1'b0}}, rs1} : rs1_data;

  always_comb begin
    case (funct3)
      `CSR_OP_RW,
      `CSR_OP_RWI: new_value = operand;                 // plain write
      `CSR_OP_RS,
      `CSR_OP_RSI: new_value = old_value | operand;     // set bits
      `CSR_OP_RC,
      `CSR_OP_RCI: new_value = old_value & ~operand;    // clear bits
      default:     new_value = '0;
    endcase
  end

endmodule

// ==== src/csr_regfile.sv ====
// csr register file: storage, address decode, read mux, trap side updates and registered outputs
`timescale 1ns/10ps
`include "csr_config.svh"

module csr_regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 clk_en,
  input  logic                 writeback_change_pc,
  input  csr_pkg::csr_instr_t  instr,
  input  csr_pkg::irq_t        irq,
  input  logic [`CSR_XLEN-1:0] pc,
  input  csr_pkg::trap_cmd_t   cmd,
  input  logic [`CSR_XLEN-1:0] new_value,
  output logic [`CSR_XLEN-1:0] old_value,
  output csr_pkg::csr_state_t  state,
  output logic [`CSR_XLEN-1:0] csr_out,
  output logic [`CSR_XLEN-1:0] trap_address,
  output logic [`CSR_XLEN-1:0] return_address
);

  localparam logic [`CSR_XLEN-1:0] TRAP_RESET = `CSR_TRAP_ADDR_RESET;

  logic                 mstatus_mie, mstatus_mpie;
  logic [1:0]           mstatus_mpp;
  logic                 mie_meie, mie_mtie, mie_msie;
  logic                 mip_meip, mip_mtip, mip_msip;  // sampled pins
  logic [`CSR_XLEN-3:0] mtvec_base;                    // word aligned base
  logic [1:0]           mtvec_mode;                    // 0 direct, 1 vectored
  logic [`CSR_XLEN-1:0] mscratch, mepc;
  logic                 mcause_int;
  logic [3:0]           mcause_code;
  logic                 wr_en;
  logic [`CSR_XLEN-1:0] vec_addr;                      // base + 4 * cause

  // write only for a live csr op that is not being flushed
  assign wr_en = instr.valid & (instr.funct3 != 3'b000) & clk_en & ~writeback_change_pc;
  assign vec_addr = {mtvec_base, 2'b00} + {{(`CSR_XLEN-6){1'b0}}, cmd.cause, 2'b00};

  // read mux, unmapped and id registers read zero
  always_comb begin
    old_value = '0;
    case (instr.addr)
      `CSR_ADDR_MSTATUS: begin
        old_value[3]     = mstatus_mie;
        old_value[7]     = mstatus_mpie;
        old_value[12:11] = mstatus_mpp;
      end
      `CSR_ADDR_MISA:     old_value = `CSR_MISA_VALUE;
      `CSR_ADDR_MIE: begin
        old_value[3]  = mie_msie;
        old_value[7]  = mie_mtie;
        old_value[11] = mie_meie;
      end
      `CSR_ADDR_MTVEC:    old_value = {mtvec_base, mtvec_mode};
      `CSR_ADDR_MSCRATCH: old_value = mscratch;
      `CSR_ADDR_MEPC:     old_value = mepc;
      `CSR_ADDR_MCAUSE: begin
        old_value[`CSR_XLEN-1] = mcause_int;
        old_value[3:0]         = mcause_code;
      end
      `CSR_ADDR_MIP: begin
        old_value[3]  = mip_msip;
        old_value[7]  = mip_mtip;
        old_value[11] = mip_meip;
      end
      default:            old_value = '0;
    endcase
  end

  assign state = '{mstatus_mie: mstatus_mie, meie: mie_meie, msie: mie_msie, mtie: mie_mtie,
                   meip: mip_meip, msip: mip_msip, mtip: mip_mtip, mtvec_vec: mtvec_mode[0]};

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      mstatus_mie    <= 1'b0;
      mstatus_mpie   <= 1'b0;
      mstatus_mpp    <= 2'b11;  // machine mode only
      {mie_meie, mie_mtie, mie_msie} <= 3'b000;
      {mip_meip, mip_mtip, mip_msip} <= 3'b000;
      mtvec_base     <= TRAP_RESET[`CSR_XLEN-1:2];
      mtvec_mode     <= TRAP_RESET[1:0];
      mscratch       <= '0;
      mepc           <= '0;
      mcause_int     <= 1'b0;
      mcause_code    <= 4'd0;
      csr_out        <= '0;
      trap_address   <= {TRAP_RESET[`CSR_XLEN-1:2], 2'b00};
      return_address <= '0;
    end else begin
      {mip_meip, mip_mtip, mip_msip} <= {irq.ext, irq.timer, irq.sw};  // every edge
      // software write wins over trap and mret on mstatus
      if (wr_en && instr.addr == `CSR_ADDR_MSTATUS) begin
        mstatus_mie  <= new_value[3];
        mstatus_mpie <= new_value[7];
        mstatus_mpp  <= new_value[12:11];
      end else if (cmd.take_trap) begin
        mstatus_mpie <= mstatus_mie;  // remember enable, block nesting
        mstatus_mie  <= 1'b0;
        mstatus_mpp  <= 2'b11;
      end else if (cmd.take_mret) begin
        mstatus_mie  <= mstatus_mpie;
        mstatus_mpie <= 1'b1;
        mstatus_mpp  <= 2'b11;
      end
      if (wr_en && instr.addr == `CSR_ADDR_MIE) begin
        {mie_meie, mie_mtie, mie_msie} <= {new_value[11], new_value[7], new_value[3]};
      end
      if (wr_en && instr.addr == `CSR_ADDR_MTVEC) begin
        mtvec_base <= new_value[`CSR_XLEN-1:2];
        mtvec_mode <= new_value[1:0];
      end
      if (wr_en && instr.addr == `CSR_ADDR_MSCRATCH) mscratch <= new_value;
      // trap entry overrides a software write of mepc or mcause
      if (cmd.take_trap) begin
        mepc        <= pc;
        mcause_int  <= cmd.is_interrupt;
        mcause_code <= cmd.cause;
      end else begin
        if (wr_en && instr.addr == `CSR_ADDR_MEPC) mepc <= {new_value[`CSR_XLEN-1:2], 2'b00};
        if (wr_en && instr.addr == `CSR_ADDR_MCAUSE) begin
          mcause_int  <= new_value[`CSR_XLEN-1];
          mcause_code <= new_value[3:0];
        end
      end
      if (clk_en) begin
        csr_out        <= old_value;  // old value goes to rd
        return_address <= mepc;       // mepc before this edge
        // only interrupts use the vector table
        trap_address   <= (mtvec_mode[0] && cmd.is_interrupt) ? vec_addr
                                                              : {mtvec_base, 2'b00};
      end
    end
  end

endmodule

// ==== src/csr_unit.sv ====
// csr unit: machine-mode csr file with trap entry and mret for an rv32i execute stage
`timescale 1ns/10ps
`include "csr_config.svh"

module csr_unit (
  input  logic                 clk,
  input  logic                 rst,                  // async, active low
  input  logic                 clk_en,               // stage enable
  input  logic                 writeback_change_pc,  // flush of this stage
  input  csr_pkg::csr_instr_t  instr,
  input  csr_pkg::irq_t        irq,
  input  csr_pkg::except_t     exc,
  input  logic [`CSR_XLEN-1:0] pc,
  output logic [`CSR_XLEN-1:0] csr_out,              // old csr value for rd
  output logic [`CSR_XLEN-1:0] trap_address,
  output logic [`CSR_XLEN-1:0] return_address,       // mepc
  output logic                 go_to_trap_q,
  output logic                 return_from_trap_q
);

  csr_pkg::csr_state_t  state;      // regfile to controller
  csr_pkg::trap_cmd_t   cmd;        // controller to regfile
  logic [`CSR_XLEN-1:0] old_value;  // current value at instr.addr
  logic [`CSR_XLEN-1:0] new_value;  // value after the rmw op

  csr_trap_ctrl u_trap_ctrl (
    .clk                (clk),
    .rst                (rst),
    .clk_en             (clk_en),
    .writeback_change_pc(writeback_change_pc),
    .exc                (exc),
    .state              (state),
    .cmd                (cmd),
    .go_to_trap_q       (go_to_trap_q),
    .return_from_trap_q (return_from_trap_q)
  );

  csr_rmw_alu u_rmw_alu (
    .funct3   (instr.funct3),
    .old_value(old_value),
    .rs1      (instr.rs1),
    .rs1_data (instr.rs1_data),
    .new_value(new_value)
  );

  csr_regfile u_regfile (
    .clk                (clk),
    .rst                (rst),
    .clk_en             (clk_en),
    .writeback_change_pc(writeback_change_pc),
    .instr              (instr),
    .irq                (irq),
    .pc                 (pc),
    .cmd                (cmd),
    .new_value          (new_value),
    .old_value          (old_value),
    .state              (state),
    .csr_out            (csr_out),
    .trap_address       (trap_address),
    .return_address     (return_address)
  );

endmodule

// ==== tests/csr_unit_props.sv ====
// csr unit pulse properties: trap and return pulses never overlap, trap pulse lasts one cycle
`timescale 1ns/10ps

module csr_unit_props (
  input logic clk,
  input logic rst,
  input logic go_to_trap_q,
  input logic return_from_trap_q
);

  int assert_fails = 0;  // failed assertions, summed into the final count

  // fetch gets one redirect per cycle at most
  no_trap_and_return: assert property (
    @(posedge clk) disable iff (!rst) !(go_to_trap_q && return_from_trap_q)
  ) else begin
    assert_fails++;
    $error("go_to_trap_q and return_from_trap_q high in the same cycle");
  end

  // one trap event enters once
  single_trap_pulse: assert property (
    @(posedge clk) disable iff (!rst) go_to_trap_q |=> !go_to_trap_q
  ) else begin
    assert_fails++;
    $error("go_to_trap_q high for two cycles in a row");
  end

endmodule

bind csr_unit csr_unit_props u_props (
  .clk               (clk),
  .rst               (rst),
  .go_to_trap_q      (go_to_trap_q),
  .return_from_trap_q(return_from_trap_q)
);

// ==== tests/csr_unit_tb.sv ====
// csr unit testbench: directed tests of csr ops, trap entry, mret and blocked cases
`timescale 1ns/10ps
`include "csr_config.svh"

module csr_unit_tb;

  localparam int CLK_PERIOD      = 10;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 200;

  logic                 clk;
  logic                 rst;
  logic                 clk_en;
  logic                 writeback_change_pc;
  csr_pkg::csr_instr_t  instr;
  csr_pkg::irq_t        irq;
  csr_pkg::except_t     exc;
  logic [`CSR_XLEN-1:0] pc;
  logic [`CSR_XLEN-1:0] csr_out;
  logic [`CSR_XLEN-1:0] trap_address;
  logic [`CSR_XLEN-1:0] return_address;
  logic                 go_to_trap_q;
  logic                 return_from_trap_q;

  integer      seed = 32'h1baa_330a;  // fixed stimulus seed
  int          errors = 0;
  int          checks = 0;
  logic [31:0] scratch_model;         // expected mscratch contents
  logic [31:0] trap_pc;               // pc saved by the interrupt trap

  csr_unit u_csr_unit (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // watchdog, sized from the test count
  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("watchdog timeout: tests did not finish within %0d cycles",
             NUM_TESTS * CYCLES_PER_TEST);
    $display("Verification failed");
    $finish;
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  // all inputs quiet, stage enabled
  task automatic idle_inputs();
    clk_en              = 1'b1;
    writeback_change_pc = 1'b0;
    instr               = '0;
    irq                 = '0;
    exc                 = '0;
  endtask

  // one csr instruction for one cycle, returns csr_out after the edge
  task automatic csr_op(input logic [2:0] op, input logic [11:0] addr, input logic [4:0] rs1,
                        input logic [31:0] data, output logic [31:0] old);
    instr.valid    = 1'b1;
    instr.funct3   = op;
    instr.addr     = addr;
    instr.rs1      = rs1;
    instr.rs1_data = data;
    @(posedge clk);
    #1;
    old         = csr_out;
    instr.valid = 1'b0;
  endtask

  // csrrs with x0, reads without changing
  task automatic csr_read(input logic [11:0] addr, output logic [31:0] value);
    csr_op(`CSR_OP_RS, addr, 5'd0, 32'd0, value);
  endtask

  task automatic wait_for_trap(input int max_cycles, output logic seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < max_cycles) begin
      @(posedge clk);
      #1;
      seen = go_to_trap_q;
      n++;
    end
  endtask

  // write, set and clear rules, immediate forms take zimm zero extended
  function automatic logic [31:0] next_csr_value(input logic [2:0] op, input logic [31:0] cur,
                                                 input logic [4:0] zimm, input logic [31:0] src);
    case (op)
      `CSR_OP_RW:  next_csr_value = src;
      `CSR_OP_RS:  next_csr_value = cur | src;
      `CSR_OP_RC:  next_csr_value = cur & ~src;
      `CSR_OP_RWI: next_csr_value = {27'd0, zimm};
      `CSR_OP_RSI: next_csr_value = cur | {27'd0, zimm};
      `CSR_OP_RCI: next_csr_value = cur & ~{27'd0, zimm};
      default:     next_csr_value = 32'd0;
    endcase
  endfunction

  task automatic rmw_on_mscratch();
    logic [2:0]  ops [6];
    logic [11:0] ids [4];
    logic [31:0] data;
    logic [4:0]  zimm;
    logic [31:0] got;
    ops = '{`CSR_OP_RW, `CSR_OP_RS, `CSR_OP_RC, `CSR_OP_RWI, `CSR_OP_RSI, `CSR_OP_RCI};
    ids = '{`CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID, `CSR_ADDR_MIMPID, `CSR_ADDR_MHARTID};
    scratch_model = 32'd0;  // reset value
    for (int i = 0; i < 6; i++) begin
      data = $random(seed);
      zimm = $random(seed);
      csr_op(ops[i], `CSR_ADDR_MSCRATCH, zimm, data, got);
      check_value(got, scratch_model, $sformatf("op %0d returns old mscratch", i));
      scratch_model = next_csr_value(ops[i], scratch_model, zimm, data);
      csr_read(`CSR_ADDR_MSCRATCH, got);
      check_value(got, scratch_model, $sformatf("mscratch after op %0d", i));
    end
    csr_read(`CSR_ADDR_MISA, got);
    check_value(got, 32'h4000_0100, "misa value");
    for (int i = 0; i < 4; i++) begin
      csr_read(ids[i], got);
      check_value(got, 32'd0, $sformatf("id register 0x%03h", ids[i]));
    end
  endtask

  task automatic ecall_direct_trap();
    logic [31:0] got;
    csr_op(`CSR_OP_RW, `CSR_ADDR_MTVEC, 5'd1, 32'h0000_1000, got);  // direct mode
    pc        = 32'h0000_0a40;
    exc.ecall = 1'b1;
    @(posedge clk);
    #1;
    exc.ecall = 1'b0;
    check_value(go_to_trap_q, 1'b1, "trap pulse after ecall");
    check_value(trap_address, 32'h0000_1000, "direct trap address");
    @(posedge clk);
    #1;
    check_value(go_to_trap_q, 1'b0, "trap pulse lasts one cycle");
    csr_read(`CSR_ADDR_MEPC, got);
    check_value(got, 32'h0000_0a40, "mepc holds ecall pc");
    csr_read(`CSR_ADDR_MCAUSE, got);
    check_value(got, 32'd11, "mcause for ecall");
  endtask

  task automatic irq_vectored_trap();
    logic [31:0] got;
    logic        seen;
    csr_op(`CSR_OP_RW, `CSR_ADDR_MTVEC, 5'd1, 32'h0000_2001, got);  // vectored
    csr_op(`CSR_OP_RW, `CSR_ADDR_MIE, 5'd1, 32'h0000_0880, got);    // meie and mtie
    csr_op(`CSR_OP_RSI, `CSR_ADDR_MSTATUS, 5'd8, 32'd0, got);       // global mie
    trap_pc   = 32'h0000_0b7c;
    pc        = trap_pc;
    irq.ext   = 1'b1;
    irq.timer = 1'b1;
    wait_for_trap(8, seen);
    if (!seen) begin
      errors++;
      $display("no trap pulse within 8 cycles of the external and timer interrupts");
    end
    check_value(trap_address, 32'h0000_202c, "vectored trap address, external irq");
    irq = '0;
    csr_read(`CSR_ADDR_MCAUSE, got);
    check_value(got, 32'h8000_000b, "mcause for external irq");
    csr_read(`CSR_ADDR_MSTATUS, got);
    check_value(got, 32'h0000_1880, "mstatus after trap, mie 0 mpie 1 mpp 3");
  endtask

  task automatic mret_return();
    logic [31:0] got;
    exc.mret = 1'b1;
    @(posedge clk);
    #1;
    exc.mret = 1'b0;
    check_value(return_from_trap_q, 1'b1, "return pulse after mret");
    check_value(return_address, trap_pc, "return address is saved mepc");
    csr_read(`CSR_ADDR_MSTATUS, got);
    check_value(got[3], 1'b1, "mstatus mie restored");
  endtask

  task automatic blocked_cases();
    logic [31:0] got;
    // software irq with msie clear
    csr_op(`CSR_OP_RW, `CSR_ADDR_MIE, 5'd1, 32'h0000_0800, got);
    irq.sw = 1'b1;
    repeat (5) begin
      @(posedge clk);
      #1;
      check_value(go_to_trap_q, 1'b0, "no trap for disabled irq");
    end
    csr_read(`CSR_ADDR_MIP, got);
    check_value(got, 32'h0000_0008, "msip pending while pin high");
    irq.sw = 1'b0;
    // flushed illegal strobe and mscratch write
    writeback_change_pc = 1'b1;
    exc.illegal         = 1'b1;
    csr_op(`CSR_OP_RW, `CSR_ADDR_MSCRATCH, 5'd2, $random(seed), got);
    writeback_change_pc = 1'b0;
    exc.illegal         = 1'b0;
    check_value(go_to_trap_q, 1'b0, "no trap for flushed illegal");
    csr_read(`CSR_ADDR_MSCRATCH, got);
    check_value(got, scratch_model, "mscratch unchanged by flushed write");
    csr_read(`CSR_ADDR_MCAUSE, got);
    check_value(got, 32'h8000_000b, "mcause unchanged by flushed illegal");
    // stalled stage holds csr_out and takes nothing
    csr_read(`CSR_ADDR_MSCRATCH, got);
    clk_en       = 1'b0;
    exc.ecall    = 1'b1;
    instr.addr   = `CSR_ADDR_MISA;
    repeat (3) begin
      @(posedge clk);
      #1;
      check_value(csr_out, scratch_model, "csr_out held while stalled");
      check_value(go_to_trap_q, 1'b0, "no trap while stalled");
    end
    csr_op(`CSR_OP_RW, `CSR_ADDR_MSCRATCH, 5'd3, ~scratch_model, got);  // write while stalled
    exc.ecall = 1'b0;
    clk_en    = 1'b1;
    csr_read(`CSR_ADDR_MSCRATCH, got);
    check_value(got, scratch_model, "mscratch unchanged by stalled write");
    csr_read(`CSR_ADDR_MCAUSE, got);
    check_value(got, 32'h8000_000b, "mcause unchanged by stalled ecall");
  endtask

  initial begin
    rst = 1'b0;
    pc  = '0;
    idle_inputs();
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b1;
    check_value(go_to_trap_q, 1'b0, "go_to_trap_q after reset");
    check_value(return_from_trap_q, 1'b0, "return_from_trap_q after reset");
    check_value(csr_out, 32'd0, "csr_out after reset");
    check_value(trap_address, `CSR_TRAP_ADDR_RESET, "trap_address after reset");
    rmw_on_mscratch();
    ecall_direct_trap();
    irq_vectored_trap();
    mret_return();
    blocked_cases();
    idle_inputs();
    repeat (2) @(posedge clk);
    $display("checks run: %0d, value errors: %0d, assertion errors: %0d",
             checks, errors, u_csr_unit.u_props.assert_fails);
    if (errors + u_csr_unit.u_props.assert_fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== csr_unit.f ====
+incdir+src
src/csr_pkg.sv
src/csr_trap_ctrl.sv
src/csr_rmw_alu.sv
src/csr_regfile.sv
src/csr_unit.sv
tests/csr_unit_props.sv
tests/csr_unit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - include_dirs:
      - src
    files:
      - src/csr_pkg.sv
      - src/csr_trap_ctrl.sv
      - src/csr_rmw_alu.sv
      - src/csr_regfile.sv
      - src/csr_unit.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/csr_unit_props.sv
      - tests/csr_unit_tb.sv
